// File: test/z3_stimulus.txt
# op addr fc nds data nberr, all numbers hex
# CRD/MRD compare read data, CWR/MWR write it, MISS expects no nSLAVEN
CRD  FF000000 1 0 AFFFFFFF 1
CRD  FF000004 1 0 0FFFFFFF 1
CRD  FF000008 2 0 EFFFFFFF 1
CRD  FF00000C 1 0 7FFFFFFF 1
CRD  FF000010 1 0 BFFFFFFF 1
CRD  FF000024 1 0 0FFFFFFF 1
CRD  FF00002C 2 0 4FFFFFFF 1
CRD  FF000040 1 0 FFFFFFFF 1
MISS 40000000 1 0 00000000 1
CWR  FF000044 1 0 00004000 1
MISS FF000000 1 0 00000000 1
MWR  40000010 1 0 11223344 1
MRD  40000010 1 0 11223344 1
MWR  40000010 2 C AABBCCDD 1
MRD  40000010 1 0 1122CCDD 1
MWR  43FFFFF0 1 0 CAFEF00D 1
MRD  43FFFFF0 2 0 CAFEF00D 1
MRD  40000100 1 0 5A000040 1
MRD  40000010 1 0 1122CCDD 0
MISS 40000010 0 0 00000000 1
MISS 40000010 3 0 00000000 1
MISS 44000000 1 0 00000000 1

// File: filelist.f
logic/z3_pkg.sv
logic/z3_bus_capture.sv
logic/z3_autoconfig.sv
logic/z3_slave_fsm.sv
logic/z3_card.sv
test/z3_card_tb.sv

// File: Bender.yml
package:
  name: z3_card

sources:
  # design, package first
  - logic/z3_pkg.sv
  - logic/z3_bus_capture.sv
  - logic/z3_autoconfig.sv
  - logic/z3_slave_fsm.sv
  - logic/z3_card.sv
  # testbench
  - target: test
    files:
      - test/z3_card_tb.sv

// File: test/z3_card_tb.sv
// run from the project root; the 256-word memory model aliases on word address bits 7..0
`timescale 1ns/1ns

module z3_card_tb import z3_pkg::*; ();

	localparam int RESET_CYCLES = 16;
	localparam int MAX_LINES    = 64;
	localparam int SLAVEN_WAIT  = 10;
	localparam int DTACK_WAIT   = 40;
	localparam int MISS_WINDOW  = 20;

	logic clk;
	logic nIORST;

	// Zorro III side
	logic        read;
	logic [1:0]  fc;
	logic        nfcs;
	logic        doe;
	logic [3:0]  nds;
	logic        nberr;
	logic        ncfginn;
	logic [7:2]  a;
	logic [31:8] ad_in;
	logic [7:0]  sd_in;
	logic        nslaven;
	logic        ndtack;
	logic        ncfgoutn;
	logic [31:8] ad_out;
	logic [7:0]  sd_out;
	logic        data_oe;

	// memory side
	logic                  mem_stb;
	logic                  mem_we;
	logic [MEM_ADDR_W-1:0] mem_addr;
	logic [3:0]            mem_be;
	logic [DATA_W-1:0]     mem_wdata;
	logic [DATA_W-1:0]     mem_rdata;
	logic                  mem_ack;

	// stimulus table
	logic [31:0] op_q   [MAX_LINES];
	logic [31:0] addr_q [MAX_LINES];
	logic [1:0]  fc_q   [MAX_LINES];
	logic [3:0]  nds_q  [MAX_LINES];
	logic [31:0] data_q [MAX_LINES];
	logic        berr_q [MAX_LINES];
	int          n_lines = 0;
	bit          stim_loaded = 1'b0;

	int check_count    = 0;
	int mismatch_count = 0;
	int other_errors   = 0;

	// last request seen by the memory model
	int                    req_count = 0;
	logic [MEM_ADDR_W-1:0] req_addr;
	logic [3:0]            req_be;
	logic                  req_we;
	logic [DATA_W-1:0]     req_wdata;

	logic [DATA_W-1:0] mem_words [256];
	logic [255:0]      mem_valid;
	logic [31:0]       lfsr_q;

	z3_card u_dut (
		.clk         (clk),
		.nIORST      (nIORST),
		.read_i      (read),
		.fc_i        (fc),
		.nfcs_i      (nfcs),
		.doe_i       (doe),
		.nds_i       (nds),
		.nberr_i     (nberr),
		.ncfginn_i   (ncfginn),
		.a_i         (a),
		.ad_i        (ad_in),
		.sd_i        (sd_in),
		.nslaven_o   (nslaven),
		.ndtack_o    (ndtack),
		.ncfgoutn_o  (ncfgoutn),
		.ad_o        (ad_out),
		.sd_o        (sd_out),
		.data_oe_o   (data_oe),
		.mem_stb_o   (mem_stb),
		.mem_we_o    (mem_we),
		.mem_addr_o  (mem_addr),
		.mem_be_o    (mem_be),
		.mem_wdata_o (mem_wdata),
		.mem_rdata_i (mem_rdata),
		.mem_ack_i   (mem_ack)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ------------------------------
	// helpers
	// ------------------------------
	// galois form with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 32'h80200003;
		return n;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		check_count++;
		assert (got === exp) else begin
			mismatch_count++;
			$display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_idle_outputs();
		check_value("nslaven_o", nslaven, 1);
		check_value("ndtack_o", ndtack, 1);
		check_value("ncfgoutn_o", ncfgoutn, 1);
		check_value("mem_stb_o", mem_stb, 0);
		check_value("data_oe_o", data_oe, 0);
	endtask

	// in the address phase AD31..8 and A7..2 carry the address
	task automatic drive_address(input logic is_read, input logic [31:0] addr,
			input logic [1:0] fc_val, input logic berr_n);
		read  = is_read;
		fc    = fc_val;
		nberr = berr_n;
		a     = addr[7:2];
		ad_in = addr[31:8];
		nfcs  = 1'b0;
	endtask

	task automatic release_bus();
		nfcs  = 1'b1;
		doe   = 1'b0;
		nds   = 4'hF;
		nberr = 1'b1;
	endtask

	// access that must not select the card at all
	task automatic expect_no_select(input logic [31:0] addr, input logic [1:0] fc_val,
			input logic [3:0] nds_val);
		int cyc;
		bit sel_seen;
		bit stb_seen;
		sel_seen = 1'b0;
		stb_seen = 1'b0;
		@(negedge clk);
		drive_address(1'b1, addr, fc_val, 1'b1);
		for (cyc = 0; cyc < MISS_WINDOW; cyc++) begin
			@(negedge clk);
			if (cyc == 2) begin
				doe = 1'b1;
				nds = nds_val;
			end
			if (!nslaven)
				sel_seen = 1'b1;
			if (mem_stb)
				stb_seen = 1'b1;
		end
		assert (!sel_seen) else begin
			other_errors++;
			$display("card asserted nSLAVEN for address %h with fc %0d", addr, fc_val);
		end
		assert (!stb_seen) else begin
			other_errors++;
			$display("memory request issued for unselected address %h", addr);
		end
		release_bus();
	endtask

	// full bus cycle that waits for nSLAVEN and then DTACK
	task automatic bus_cycle(input logic is_read, input logic is_card, input logic [31:0] addr,
			input logic [1:0] fc_val, input logic [3:0] nds_val, input logic [31:0] data,
			input logic berr_n);
		int waited;
		logic [31:0] got;
		logic [3:0]  be_exp;
		// byte enables are the inverted data strobes
		be_exp = ~nds_val;
		req_count = 0;
		@(negedge clk);
		drive_address(is_read, addr, fc_val, berr_n);
		repeat (3) @(negedge clk);
		doe = 1'b1;
		nds = nds_val;
		// lane order AD31..24, SD7..0, AD23..8
		if (!is_read) begin
			ad_in = {data[31:24], data[15:0]};
			sd_in = data[23:16];
		end
		waited = 0;
		while (nslaven && waited < SLAVEN_WAIT) begin
			@(negedge clk);
			waited++;
		end
		assert (!nslaven) else begin
			other_errors++;
			$display("no nSLAVEN within %0d clocks for address %h", SLAVEN_WAIT, addr);
		end
		waited = 0;
		while (ndtack && waited < DTACK_WAIT) begin
			@(negedge clk);
			waited++;
		end
		assert (!ndtack) else begin
			other_errors++;
			$display("no DTACK within %0d clocks for address %h", DTACK_WAIT, addr);
		end
		if (!ndtack) begin
			got = {ad_out[31:24], sd_out, ad_out[23:8]};
			// lanes only driven on reads without a bus error
			check_value("data_oe_o", data_oe, is_read & berr_n);
			if (is_read && berr_n)
				check_value("read data", got, data);
			if (is_card) begin
				check_value("memory request count", req_count, 1);
				check_value("mem_addr_o", req_addr, addr[25:2]);
				check_value("mem_we_o", req_we, !is_read);
				if (!is_read) begin
					check_value("mem_be_o", req_be, be_exp);
					check_value("mem_wdata_o", req_wdata, data);
				end
			end else begin
				check_value("memory request count", req_count, 0);
			end
		end
		release_bus();
		@(negedge clk);
		check_value("ndtack_o", ndtack, 1);
		check_value("nslaven_o", nslaven, 1);
	endtask

	// ------------------------------
	// memory model
	// ------------------------------
	initial begin : memory_model
		int delay;
		int k;
		logic [DATA_W-1:0] word;
		mem_ack   = 1'b0;
		mem_rdata = '0;
		mem_valid = '0;
		lfsr_q    = 32'had6cd171;
		forever begin
			@(negedge clk);
			mem_ack = 1'b0;
			if (mem_stb) begin
				// three lfsr bits give 0..7 clocks of latency
				delay = 0;
				for (k = 0; k < 3; k++) begin
					delay  = (delay << 1) | lfsr_q[0];
					lfsr_q = lfsr_step(lfsr_q);
				end
				repeat (delay) @(negedge clk);
				req_count++;
				req_addr  = mem_addr;
				req_be    = mem_be;
				req_we    = mem_we;
				req_wdata = mem_wdata;
				// unwritten words read back a pattern of the full word address
				if (mem_valid[mem_addr[7:0]])
					word = mem_words[mem_addr[7:0]];
				else
					word = {8'h5A, mem_addr};
				if (mem_we) begin
					for (k = 0; k < 4; k++)
						if (mem_be[k])
							word[8*k +: 8] = mem_wdata[8*k +: 8];
					mem_words[mem_addr[7:0]] = word;
					mem_valid[mem_addr[7:0]] = 1'b1;
				end else begin
					mem_rdata = word;
				end
				mem_ack = 1'b1;
			end
		end
	end

	// ------------------------------
	// watchdog
	// ------------------------------
	initial begin : watchdog
		wait (stim_loaded);
		if (n_lines > 0) begin
			// 200 clocks per stimulus line plus reset
			repeat (n_lines * 200 + RESET_CYCLES) @(posedge clk);
			$display("timeout after %0d clocks, the run did not finish",
				n_lines * 200 + RESET_CYCLES);
			$display("checks: %0d, mismatches: %0d, other errors: %0d",
				check_count, mismatch_count, other_errors);
			$display("Something failed");
			$finish;
		end
	end

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin : main_seq
		int fd;
		int code;
		int ch;
		int i;
		bit done;
		bit is_read;
		bit is_card;
		logic [31:0] op_text;
		logic [31:0] f_addr;
		logic [31:0] f_data;
		logic [1:0]  f_fc;
		logic [3:0]  f_nds;
		logic        f_berr;

		// bus idle and card first in the config chain
		nIORST  = 1'b0;
		read    = 1'b1;
		fc      = 2'b01;
		nfcs    = 1'b1;
		doe     = 1'b0;
		nds     = 4'hF;
		nberr   = 1'b1;
		ncfginn = 1'b0;
		a       = '0;
		ad_in   = '0;
		sd_in   = '0;

		fd = $fopen("test/z3_stimulus.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("cannot open the stimulus file test/z3_stimulus.txt");
		end else begin
			done = 1'b0;
			while (!done) begin
				op_text = '0;
				code = $fscanf(fd, "%s", op_text);
				if (code != 1) begin
					done = 1'b1;
				end else if (op_text == "#") begin
					// skip rest of a comment line
					ch = $fgetc(fd);
					while (ch != "\n" && ch != -1)
						ch = $fgetc(fd);
				end else begin
					code = $fscanf(fd, "%h %h %h %h %h", f_addr, f_fc, f_nds, f_data, f_berr);
					if (code != 5 || n_lines >= MAX_LINES) begin
						other_errors++;
						$display("stimulus line %0d is malformed or beyond the table", n_lines + 1);
						done = 1'b1;
					end else begin
						op_q[n_lines]   = op_text;
						addr_q[n_lines] = f_addr;
						fc_q[n_lines]   = f_fc;
						nds_q[n_lines]  = f_nds;
						data_q[n_lines] = f_data;
						berr_q[n_lines] = f_berr;
						n_lines++;
					end
				end
			end
			$fclose(fd);
			if (n_lines == 0) begin
				other_errors++;
				$display("stimulus file holds no transactions");
			end
		end
		stim_loaded = 1'b1;

		// outputs must be idle during and right after reset
		repeat (RESET_CYCLES) @(negedge clk);
		check_idle_outputs();
		nIORST = 1'b1;
		@(negedge clk);
		check_idle_outputs();

		for (i = 0; i < n_lines; i++) begin
			is_read = (op_q[i] == "CRD") || (op_q[i] == "MRD");
			is_card = (op_q[i] == "MRD") || (op_q[i] == "MWR");
			if (op_q[i] == "MISS") begin
				expect_no_select(addr_q[i], fc_q[i], nds_q[i]);
			end else if (is_card || op_q[i] == "CRD" || op_q[i] == "CWR") begin
				bus_cycle(is_read, is_card, addr_q[i], fc_q[i], nds_q[i], data_q[i], berr_q[i]);
				// base register write passes the config chain on
				if (op_q[i] == "CWR" && addr_q[i][8:0] == 9'h044)
					check_value("ncfgoutn_o", ncfgoutn, 0);
			end else begin
				other_errors++;
				$display("unknown operation on stimulus line %0d", i + 1);
			end
			repeat (3) @(negedge clk);
		end

		$display("checks: %0d, mismatches: %0d, other errors: %0d",
			check_count, mismatch_count, other_errors);
		if (mismatch_count == 0 && other_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: logic/z3_card.sv
// tri-state lanes are split into in, out and a shared enable; the memory must answer every stb
`timescale 1ns/1ns

module z3_card import z3_pkg::*; (
	input  logic                  clk,
	input  logic                  nIORST,

	// Zorro III inputs
	input  logic                  read_i,
	input  logic [1:0]            fc_i,
	input  logic                  nfcs_i,
	input  logic                  doe_i,
	input  logic [3:0]            nds_i,
	input  logic                  nberr_i,
	input  logic                  ncfginn_i,
	input  logic [7:2]            a_i,
	input  logic [31:8]           ad_i,
	input  logic [7:0]            sd_i,

	// Zorro III outputs
	output logic                  nslaven_o,
	output logic                  ndtack_o,
	output logic                  ncfgoutn_o,
	output logic [31:8]           ad_o,
	output logic [7:0]            sd_o,
	output logic                  data_oe_o,

	// local memory request port
	output logic                  mem_stb_o,
	output logic                  mem_we_o,
	output logic [MEM_ADDR_W-1:0] mem_addr_o,
	output logic [3:0]            mem_be_o,
	output logic [DATA_W-1:0]     mem_wdata_o,
	input  logic [DATA_W-1:0]     mem_rdata_i,
	input  logic                  mem_ack_i
);

	// capture to FSM
	logic                 nfcs_s;
	logic                 doe_s;
	logic [3:0]           nds_s;
	logic [ADDR_W-1:0]    addr;
	logic                 card_hit;
	logic                 cfg_hit;

	// capture and FSM to autoconfig
	logic [CFG_IDX_W-1:0] cfg_idx;
	logic                 cfg_wr;
	logic [15:0]          cfg_wdata;

	// autoconfig back out
	logic [3:0]           cfg_nibble;
	logic [31:16]         base;
	logic                 configured;

	// ------------------------------
	// strobes, address, decode
	// ------------------------------
	z3_bus_capture u_capture (
		.clk          (clk),
		.nIORST       (nIORST),
		.nfcs_i       (nfcs_i),
		.doe_i        (doe_i),
		.nds_i        (nds_i),
		.fc_i         (fc_i),
		.a_i          (a_i),
		.ad_i         (ad_i),
		.ncfginn_i    (ncfginn_i),
		.base_i       (base),
		.configured_i (configured),
		.nfcs_s_o     (nfcs_s),
		.doe_s_o      (doe_s),
		.nds_s_o      (nds_s),
		.addr_o       (addr),
		.card_hit_o   (card_hit),
		.cfg_hit_o    (cfg_hit),
		.cfg_idx_o    (cfg_idx)
	);

	// ------------------------------
	// autoconfig registers
	// ------------------------------
	z3_autoconfig u_autoconfig (
		.clk          (clk),
		.nIORST       (nIORST),
		.cfg_idx_i    (cfg_idx),
		.cfg_wr_i     (cfg_wr),
		.wdata_i      (cfg_wdata),
		.cfg_nibble_o (cfg_nibble),
		.base_o       (base),
		.configured_o (configured),
		.ncfgoutn_o   (ncfgoutn_o)
	);

	// ------------------------------
	// bus cycle FSM
	// ------------------------------
	z3_slave_fsm u_fsm (
		.clk          (clk),
		.nIORST       (nIORST),
		.read_i       (read_i),
		.nberr_i      (nberr_i),
		.nfcs_i       (nfcs_i),
		.nfcs_s_i     (nfcs_s),
		.doe_s_i      (doe_s),
		.doe_i        (doe_i),
		.nds_s_i      (nds_s),
		.addr_i       (addr),
		.card_hit_i   (card_hit),
		.cfg_hit_i    (cfg_hit),
		.cfg_nibble_i (cfg_nibble),
		.ad_i         (ad_i),
		.sd_i         (sd_i),
		.mem_rdata_i  (mem_rdata_i),
		.mem_ack_i    (mem_ack_i),
		.nslaven_o    (nslaven_o),
		.ndtack_o     (ndtack_o),
		.ad_o         (ad_o),
		.sd_o         (sd_o),
		.data_oe_o    (data_oe_o),
		.mem_stb_o    (mem_stb_o),
		.mem_we_o     (mem_we_o),
		.mem_addr_o   (mem_addr_o),
		.mem_be_o     (mem_be_o),
		.mem_wdata_o  (mem_wdata_o),
		.cfg_wr_o     (cfg_wr),
		.wdata_o      (cfg_wdata)
	);

endmodule

// File: logic/z3_slave_fsm.sv
// one cycle in flight; the master must wait for DTACK, there is no timeout and no BERR driving
`timescale 1ns/1ns

module z3_slave_fsm import z3_pkg::*; (
	input  logic                  clk,
	input  logic                  nIORST,
	input  logic                  read_i,
	input  logic                  nberr_i,
	input  logic                  nfcs_i,
	input  logic                  nfcs_s_i,
	input  logic                  doe_s_i,
	input  logic                  doe_i,
	input  logic [3:0]            nds_s_i,
	input  logic [ADDR_W-1:0]     addr_i,
	input  logic                  card_hit_i,
	input  logic                  cfg_hit_i,
	input  logic [3:0]            cfg_nibble_i,
	input  logic [31:8]           ad_i,
	input  logic [7:0]            sd_i,
	input  logic [DATA_W-1:0]     mem_rdata_i,
	input  logic                  mem_ack_i,
	output logic                  nslaven_o,
	output logic                  ndtack_o,
	output logic [31:8]           ad_o,
	output logic [7:0]            sd_o,
	output logic                  data_oe_o,
	output logic                  mem_stb_o,
	output logic                  mem_we_o,
	output logic [MEM_ADDR_W-1:0] mem_addr_o,
	output logic [3:0]            mem_be_o,
	output logic [DATA_W-1:0]     mem_wdata_o,
	output logic                  cfg_wr_o,
	output logic [15:0]           wdata_o
);

	z3_state_e state_q;
	z3_state_e state_d;

	logic              nslaven_r;
	logic              mem_ack;
	logic              done_q;
	logic              mem_done;
	logic              wr_strobe;
	logic [DATA_W-1:0] lane_in;
	logic [DATA_W-1:0] wdata_q;
	logic [DATA_W-1:0] rdata_q;
	logic [3:0]        be_q;

	// handshake completes on an edge with both stb and ack high
	assign mem_ack = mem_stb_o & mem_ack_i;

	// read acks may already arrive while still in MATCH
	assign mem_done = mem_ack | done_q;

	assign wr_strobe = (nds_s_i != 4'hF);

	// lane order AD31..24, SD7..0, AD23..8
	assign lane_in = {ad_i[31:24], sd_i, ad_i[23:8]};

	// ------------------------------
	// next state
	// ------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE:
				if (~nfcs_s_i & (card_hit_i | cfg_hit_i))
					state_d = MATCH;
			MATCH:
				if (doe_s_i)
					state_d = DATA;
			DATA:
				if (read_i) begin
					// config reads need no memory
					if (cfg_hit_i | mem_done)
						state_d = DTACK;
				end else if (wr_strobe) begin
					state_d = WRITE_STB;
				end
			WRITE_STB:
				state_d = WRITE_WAIT;
			WRITE_WAIT:
				if (cfg_hit_i | mem_done)
					state_d = DTACK;
			DTACK:
				// hold DTACK until the master ends the cycle
				if (nfcs_i)
					state_d = IDLE;
			default:
				state_d = IDLE;
		endcase
	end

	// ------------------------------
	// control registers
	// ------------------------------
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			state_q   <= IDLE;
			nslaven_r <= 1'b1;
			mem_stb_o <= 1'b0;
			cfg_wr_o  <= 1'b0;
			done_q    <= 1'b0;
		end else begin
			state_q   <= state_d;
			// goes low one clock after MATCH is entered
			nslaven_r <= (state_q == IDLE);
			// single clock write pulse into the config registers
			cfg_wr_o  <= (state_q == WRITE_STB) & cfg_hit_i;

			if (mem_ack)
				mem_stb_o <= 1'b0;
			else if (state_q == IDLE && state_d == MATCH && card_hit_i && read_i)
				mem_stb_o <= 1'b1;
			else if (state_q == WRITE_STB && card_hit_i)
				mem_stb_o <= 1'b1;

			if (state_q == IDLE)
				done_q <= 1'b0;
			else if (mem_ack)
				done_q <= 1'b1;
		end
	end

	// ------------------------------
	// data path
	// ------------------------------
	always_ff @(posedge clk) begin
		// lanes settled by the time the two-stage strobe shows up
		if (state_q == DATA && !read_i && wr_strobe) begin
			wdata_q <= lane_in;
			be_q    <= ~nds_s_i;
		end
		// config nibble sits on D31..28, rest reads as ones
		if (state_q == DATA && read_i && cfg_hit_i)
			rdata_q <= {cfg_nibble_i, 28'hFFFFFFF};
		else if (mem_ack && read_i)
			rdata_q <= mem_rdata_i;
	end

	// memory request fields, stable for as long as stb is up
	assign mem_we_o    = ~read_i;
	assign mem_addr_o  = addr_i[MEM_ADDR_W+1:2];
	// whole word for reads, strobed bytes for writes
	assign mem_be_o    = read_i ? 4'hF : be_q;
	assign mem_wdata_o = wdata_q;
	assign wdata_o     = wdata_q[15:0];

	// bus side outputs
	assign nslaven_o = nfcs_i | nslaven_r;
	assign ndtack_o  = nfcs_i | nslaven_r | (state_q != DTACK);
	assign data_oe_o = ~nfcs_i & ~nslaven_o & doe_i & read_i & nberr_i;

	assign ad_o = {rdata_q[31:24], rdata_q[15:0]};
	assign sd_o = rdata_q[23:16];

endmodule

// File: logic/z3_autoconfig.sv
// only the base register at 0x44 is writable; no shut-up, and the card leaves config space for good
`timescale 1ns/1ns

module z3_autoconfig import z3_pkg::*; (
	input  logic                 clk,
	input  logic                 nIORST,
	input  logic [CFG_IDX_W-1:0] cfg_idx_i,
	input  logic                 cfg_wr_i,
	input  logic [15:0]          wdata_i,
	output logic [3:0]           cfg_nibble_o,
	output logic [31:16]         base_o,
	output logic                 configured_o,
	output logic                 ncfgoutn_o
);

	logic in_rom;
	logic base_wr;

	// ------------------------------
	// identity ROM read
	// ------------------------------
	// table covers index 0..15 only
	assign in_rom = (cfg_idx_i < CFG_IDX_W'(16));

	always_comb begin
		if (in_rom)
			cfg_nibble_o = CFG_ROM[cfg_idx_i[3:0]];
		else
			// unimplemented registers read back all ones
			cfg_nibble_o = 4'hF;
	end

	// ------------------------------
	// base address register
	// ------------------------------
	assign base_wr = cfg_wr_i & (cfg_idx_i == CFG_BASE_IDX);

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			base_o       <= 16'h0000;
			configured_o <= 1'b0;
		end else if (base_wr) begin
			// base comes in on the low half of the lane word
			base_o       <= wdata_i;
			configured_o <= 1'b1;
		end
	end

	// pass the chain on once we own an address
	assign ncfgoutn_o = ~configured_o;

endmodule

// File: logic/z3_bus_capture.sv
// needs the master to hold AD31..8 for three clocks after FCS falls; FC is only checked for validity
`timescale 1ns/1ns

module z3_bus_capture import z3_pkg::*; (
	input  logic                 clk,
	input  logic                 nIORST,
	input  logic                 nfcs_i,
	input  logic                 doe_i,
	input  logic [3:0]           nds_i,
	input  logic [1:0]           fc_i,
	input  logic [7:2]           a_i,
	input  logic [31:8]          ad_i,
	input  logic                 ncfginn_i,
	input  logic [31:16]         base_i,
	input  logic                 configured_i,
	output logic                 nfcs_s_o,
	output logic                 doe_s_o,
	output logic [3:0]           nds_s_o,
	output logic [ADDR_W-1:0]    addr_o,
	output logic                 card_hit_o,
	output logic                 cfg_hit_o,
	output logic [CFG_IDX_W-1:0] cfg_idx_o
);

	// first stage of the data strobe synchronizer
	logic [3:0] nds_meta;

	logic fc_ok;
	logic in_cycle;
	logic card_match;
	logic cfg_match;

	// ------------------------------
	// strobe synchronizers
	// ------------------------------
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			nfcs_s_o <= 1'b1;
			doe_s_o  <= 1'b0;
			nds_meta <= 4'hF;
			nds_s_o  <= 4'hF;
		end else begin
			nfcs_s_o <= nfcs_i;
			doe_s_o  <= doe_i;
			// data strobes get two stages, lane data is sampled behind them
			nds_meta <= nds_i;
			nds_s_o  <= nds_meta;
		end
	end

	// address latch, first edge with FCS low after it was high
	always_ff @(posedge clk) begin
		if (!nfcs_i && nfcs_s_o)
			addr_o <= {ad_i, a_i, 2'b00};
	end

	// ------------------------------
	// address decode
	// ------------------------------
	// valid memory space when FC1 and FC0 differ
	assign fc_ok = fc_i[0] ^ fc_i[1];

	// true from the edge after the latch on, so a stale address never hits
	assign in_cycle = ~nfcs_i & ~nfcs_s_o;

	assign card_match = (addr_o[ADDR_W-1:CARD_MATCH_LSB] == base_i[31:CARD_MATCH_LSB]);
	assign cfg_match  = (addr_o[ADDR_W-1:16] == CFG_SPACE_HI);

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			card_hit_o <= 1'b0;
			cfg_hit_o  <= 1'b0;
		end else begin
			// card space only once a base has been assigned
			card_hit_o <= in_cycle & fc_ok & configured_i & card_match;
			// config space only while the chain selects us
			cfg_hit_o  <= in_cycle & fc_ok & ~ncfginn_i & ~configured_i & cfg_match;
		end
	end

	// autoconfig register index
	assign cfg_idx_o = addr_o[CFG_IDX_W+1:2];

endmodule

// File: logic/z3_pkg.sv
// shared constants for the Zorro III slave; ROM nibbles are given as seen on the bus, not inverted
package z3_pkg;

	// ------------------------------
	// bus widths
	// ------------------------------
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// local memory word address, latched address bits 25..2
	localparam int MEM_ADDR_W = 24;

	// ------------------------------
	// address decode
	// ------------------------------
	// config space lives at FF00_0000, 64K
	localparam logic [15:0] CFG_SPACE_HI = 16'hFF00;

	// 64 MB card space, compare bits 31..26 only
	localparam int CARD_MATCH_LSB = 26;

	// register index is address bits 8..2
	localparam int CFG_IDX_W = 7;

	// base address register, byte offset 0x44
	localparam logic [CFG_IDX_W-1:0] CFG_BASE_IDX = 7'h11;

	// card identity, one nibble per byte offset 0x00..0x3C in steps of 4
	localparam logic [0:15][3:0] CFG_ROM = {
		4'hA, 4'h0,		// type: Z3, memory linked to pool
		4'hE, 4'h7,		// product
		4'hB, 4'hF,		// flags
		4'hF, 4'hF,		// reserved
		4'hF, 4'h0,		// manufacturer, high byte
		4'hC, 4'h4,		// manufacturer, low byte
		4'hF, 4'hF,		// serial
		4'hF, 4'hF		// serial
	};

	// ------------------------------
	// bus cycle states
	// ------------------------------
	typedef enum logic [3:0] {
		IDLE,
		MATCH,
		DATA,
		WRITE_STB,
		WRITE_WAIT,
		DTACK
	} z3_state_e;

endpackage
